//--- files.f
+incdir+tb
rtl/exec_pkg.sv
rtl/lock_if.sv
rtl/alu.sv
rtl/load_scoreboard.sv
rtl/execute_unit.sv
rtl/exec_top.sv
tb/tb_exec_top.sv

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  exec_pkg::word_t   a,
    input  exec_pkg::word_t   b,
    input  exec_pkg::alu_fn_e fn,
    output exec_pkg::word_t   y,
    output logic              cond
);
    import exec_pkg::*;

    logic               eq;
    logic               lt;
    logic               ltu;
    logic [SHAMT_W-1:0] shamt;

    // shared comparators, used by slt and the branches
    assign eq    = (a == b);
    assign lt    = ($signed(a) < $signed(b));
    assign ltu   = (a < b);
    assign shamt = b[SHAMT_W-1:0];

    // ------------------------------------------------------------------------
    // result
    // ------------------------------------------------------------------------

    always_comb begin
        case (fn)
            FN_SUB: begin
                y = a - b;
            end
            FN_SLL: begin
                y = a << shamt;
            end
            FN_SLT: begin
                y = {{(XLEN-1){1'b0}}, lt};
            end
            FN_SLTU: begin
                y = {{(XLEN-1){1'b0}}, ltu};
            end
            FN_XOR: begin
                y = a ^ b;
            end
            FN_SRL: begin
                y = a >> shamt;
            end
            FN_SRA: begin
                y = word_t'($signed(a) >>> shamt);
            end
            FN_OR: begin
                y = a | b;
            end
            FN_AND: begin
                y = a & b;
            end
            // add, and the value seen on branch compares
            default: begin
                y = a + b;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // branch condition
    // ------------------------------------------------------------------------

    always_comb begin
        case (fn)
            FN_EQ:   cond = eq;
            FN_NE:   cond = ~eq;
            FN_LT:   cond = lt;
            FN_GE:   cond = ~lt;
            FN_LTU:  cond = ltu;
            FN_GEU:  cond = ~ltu;
            default: cond = 1'b0;
        endcase
    end

endmodule

//--- rtl/exec_pkg.sv
package exec_pkg;

    // ------------------------------------------------------------------------
    // widths and constants
    // ------------------------------------------------------------------------

    localparam int unsigned XLEN      = 32;
    localparam int unsigned REG_IDX_W = 4;
    localparam int unsigned SHAMT_W   = 5;

    // RV32E register file size
    localparam int unsigned NUM_REGS  = 16;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // sequential fetch increment
    localparam word_t PC_STEP = 32'd4;

    // ------------------------------------------------------------------------
    // decoded operation
    // ------------------------------------------------------------------------

    typedef enum logic [4:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        LOAD,
        STORE
    } exec_op_e;

    // memory access width
    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_e;

    // ------------------------------------------------------------------------
    // alu function select
    // ------------------------------------------------------------------------

    typedef enum logic [3:0] {
        FN_ADD,
        FN_SUB,
        FN_SLL,
        FN_SLT,
        FN_SLTU,
        FN_XOR,
        FN_SRL,
        FN_SRA,
        FN_OR,
        FN_AND,
        // branch compares, drive cond
        FN_EQ,
        FN_NE,
        FN_LT,
        FN_GE,
        FN_LTU,
        FN_GEU
    } alu_fn_e;

endpackage

//--- rtl/exec_top.sv
`timescale 1ns/1ps

module exec_top (
    input  logic                clock,
    input  logic                reset,

    // issue
    input  logic                issue_valid,
    output logic                issue_ready,
    input  exec_pkg::exec_op_e  op,
    input  logic                use_imm,
    input  exec_pkg::mem_size_e issue_size,
    input  logic                issue_unsigned,
    input  exec_pkg::reg_idx_t  rd,
    input  exec_pkg::reg_idx_t  rs1_idx,
    input  exec_pkg::reg_idx_t  rs2_idx,
    input  exec_pkg::word_t     pc,
    input  exec_pkg::word_t     imm,
    input  exec_pkg::word_t     rs1,
    input  exec_pkg::word_t     rs2,

    // result to memory / write-back
    output logic                result_valid,
    input  logic                result_ready,
    output exec_pkg::reg_idx_t  result_rd,
    output exec_pkg::word_t     result_value,
    output logic                reg_write,
    output logic                mem_enable,
    output logic                mem_write,
    output exec_pkg::word_t     mem_addr,
    output exec_pkg::word_t     mem_wdata,
    output exec_pkg::mem_size_e mem_size,
    output logic                mem_unsigned,
    output exec_pkg::word_t     next_pc,

    // write-back completion
    input  logic                wb_done,
    input  exec_pkg::reg_idx_t  wb_rd
);

    lock_if lock_bus ();

    // completion goes straight to the scoreboard
    assign lock_bus.wb_done = wb_done;
    assign lock_bus.wb_rd   = wb_rd;

    execute_unit u_execute_unit (
        .clock          (clock),
        .reset          (reset),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .op             (op),
        .use_imm        (use_imm),
        .issue_size     (issue_size),
        .issue_unsigned (issue_unsigned),
        .rd             (rd),
        .rs1_idx        (rs1_idx),
        .rs2_idx        (rs2_idx),
        .pc             (pc),
        .imm            (imm),
        .rs1            (rs1),
        .rs2            (rs2),
        .result_valid   (result_valid),
        .result_ready   (result_ready),
        .result_rd      (result_rd),
        .result_value   (result_value),
        .reg_write      (reg_write),
        .mem_enable     (mem_enable),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_size       (mem_size),
        .mem_unsigned   (mem_unsigned),
        .next_pc        (next_pc),
        .lock           (lock_bus.unit)
    );

    load_scoreboard u_load_scoreboard (
        .clock (clock),
        .reset (reset),
        .lock  (lock_bus.board)
    );

endmodule

//--- rtl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic                clock,
    input  logic                reset,

    input  logic                issue_valid,
    output logic                issue_ready,
    input  exec_pkg::exec_op_e  op,
    input  logic                use_imm,
    input  exec_pkg::mem_size_e issue_size,
    input  logic                issue_unsigned,
    input  exec_pkg::reg_idx_t  rd,
    input  exec_pkg::reg_idx_t  rs1_idx,
    input  exec_pkg::reg_idx_t  rs2_idx,
    input  exec_pkg::word_t     pc,
    input  exec_pkg::word_t     imm,
    input  exec_pkg::word_t     rs1,
    input  exec_pkg::word_t     rs2,

    output logic                result_valid,
    input  logic                result_ready,
    output exec_pkg::reg_idx_t  result_rd,
    output exec_pkg::word_t     result_value,
    output logic                reg_write,
    output logic                mem_enable,
    output logic                mem_write,
    output exec_pkg::word_t     mem_addr,
    output exec_pkg::word_t     mem_wdata,
    output exec_pkg::mem_size_e mem_size,
    output logic                mem_unsigned,
    output exec_pkg::word_t     next_pc,

    lock_if.unit                lock
);
    import exec_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ALU,
        ST_PC,
        ST_DONE
    } state_e;

    state_e    state;
    logic      accept;

    // latched instruction
    exec_op_e  op_q;
    reg_idx_t  rd_q;
    word_t     pc_q;
    word_t     imm_q;
    word_t     rs1_q;
    word_t     rs2_q;
    mem_size_e size_q;
    logic      unsigned_q;

    // phase-one operands
    word_t     opa_q;
    word_t     opb_q;
    alu_fn_e   fn_q;

    word_t     value_q;
    logic      cond_q;
    word_t     npc_q;

    word_t     alu_a;
    word_t     alu_b;
    alu_fn_e   alu_fn;
    word_t     alu_y;
    logic      alu_cond;

    logic      is_branch;
    logic      taken;
    logic      writes_reg;

    function automatic alu_fn_e fn_of(input exec_op_e o);
        case (o)
            SUB:     return FN_SUB;
            SLL:     return FN_SLL;
            SLT:     return FN_SLT;
            SLTU:    return FN_SLTU;
            XOR:     return FN_XOR;
            SRL:     return FN_SRL;
            SRA:     return FN_SRA;
            OR:      return FN_OR;
            AND:     return FN_AND;
            BEQ:     return FN_EQ;
            BNE:     return FN_NE;
            BLT:     return FN_LT;
            BGE:     return FN_GE;
            BLTU:    return FN_LTU;
            BGEU:    return FN_GEU;
            default: return FN_ADD;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // issue handshake and lock port
    // ------------------------------------------------------------------------

    assign issue_ready  = (state == ST_IDLE) && !lock.hazard;
    assign accept       = issue_valid && issue_ready;

    assign lock.accept  = accept;
    assign lock.is_load = (op == LOAD);
    assign lock.dest    = rd;
    assign lock.src1    = rs1_idx;
    assign lock.src2    = rs2_idx;

    // ------------------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (accept) state <= ST_ALU;
                ST_ALU:  state <= ST_PC;
                ST_PC:   state <= ST_DONE;
                ST_DONE: if (result_ready) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // latch instruction and pick phase-one operands
    always_ff @(posedge clock) begin
        if (accept) begin
            op_q       <= op;
            rd_q       <= rd;
            pc_q       <= pc;
            imm_q      <= imm;
            rs1_q      <= rs1;
            rs2_q      <= rs2;
            size_q     <= issue_size;
            unsigned_q <= issue_unsigned;
            fn_q       <= fn_of(op);
            case (op)
                LUI: begin
                    opa_q <= '0;
                    opb_q <= imm;
                end
                AUIPC: begin
                    opa_q <= pc;
                    opb_q <= imm;
                end
                // link value
                JAL, JALR: begin
                    opa_q <= pc;
                    opb_q <= PC_STEP;
                end
                LOAD, STORE: begin
                    opa_q <= rs1;
                    opb_q <= imm;
                end
                BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                    opa_q <= rs1;
                    opb_q <= rs2;
                end
                default: begin
                    opa_q <= rs1;
                    opb_q <= use_imm ? imm : rs2;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // shared alu, second pass acts as the pc adder
    // ------------------------------------------------------------------------

    assign is_branch = op_q inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
    assign taken     = (is_branch && cond_q) || (op_q == JAL) || (op_q == JALR);

    always_comb begin
        if (state == ST_PC) begin
            alu_a  = (op_q == JALR) ? rs1_q : pc_q;
            alu_b  = taken ? imm_q : PC_STEP;
            alu_fn = FN_ADD;
        end else begin
            alu_a  = opa_q;
            alu_b  = opb_q;
            alu_fn = fn_q;
        end
    end

    alu u_alu (
        .a    (alu_a),
        .b    (alu_b),
        .fn   (alu_fn),
        .y    (alu_y),
        .cond (alu_cond)
    );

    always_ff @(posedge clock) begin
        if (state == ST_ALU) begin
            value_q <= alu_y;
            cond_q  <= alu_cond;
        end
        if (state == ST_PC) begin
            // jalr target is halfword aligned
            npc_q <= (op_q == JALR) ? {alu_y[XLEN-1:1], 1'b0} : alu_y;
        end
    end

    // ------------------------------------------------------------------------
    // result port, held until result_ready
    // ------------------------------------------------------------------------

    assign writes_reg   = !(is_branch || (op_q == STORE));

    assign result_valid = (state == ST_DONE);
    assign result_rd    = rd_q;
    assign result_value = value_q;
    assign reg_write    = writes_reg && (rd_q != '0);
    assign mem_enable   = (op_q == LOAD) || (op_q == STORE);
    assign mem_write    = (op_q == STORE);
    assign mem_addr     = value_q;
    assign mem_wdata    = rs2_q;
    assign mem_size     = size_q;
    assign mem_unsigned = unsigned_q;
    assign next_pc      = npc_q;

endmodule

//--- rtl/load_scoreboard.sv
`timescale 1ns/1ps

module load_scoreboard (
    input  logic  clock,
    input  logic  reset,
    lock_if.board lock
);
    import exec_pkg::*;

    logic [NUM_REGS-1:0] locked;
    logic [NUM_REGS-1:0] set_mask;
    logic [NUM_REGS-1:0] clear_mask;

    function automatic logic [NUM_REGS-1:0] reg_bit(input reg_idx_t idx);
        logic [NUM_REGS-1:0] mask;
        mask      = '0;
        mask[idx] = 1'b1;
        return mask;
    endfunction

    // x0 is never written, so a load to it takes no lock
    always_comb begin
        set_mask = '0;
        if (lock.accept && lock.is_load && (lock.dest != '0)) begin
            set_mask = reg_bit(lock.dest);
        end
    end

    always_comb begin
        clear_mask = '0;
        if (lock.wb_done) begin
            clear_mask = reg_bit(lock.wb_rd);
        end
    end

    // clear applied after set, so a same-cycle release wins
    always_ff @(posedge clock) begin
        if (reset) begin
            locked <= '0;
        end else begin
            locked <= (locked | set_mask) & ~clear_mask;
        end
    end

    // dest checked too, keeps write order behind the pending load
    assign lock.hazard = locked[lock.dest] | locked[lock.src1] | locked[lock.src2];

endmodule

//--- rtl/lock_if.sv
`timescale 1ns/1ps

interface lock_if;
    import exec_pkg::*;

    // issue side, from the execute unit
    logic     accept;
    logic     is_load;
    reg_idx_t dest;
    reg_idx_t src1;
    reg_idx_t src2;

    // write-back completion
    logic     wb_done;
    reg_idx_t wb_rd;

    // back to the execute unit
    logic     hazard;

    modport unit (
        output accept,
        output is_load,
        output dest,
        output src1,
        output src2,
        input  hazard
    );

    modport board (
        input  accept,
        input  is_load,
        input  dest,
        input  src1,
        input  src2,
        input  wb_done,
        input  wb_rd,
        output hazard
    );

endinterface

//--- tb/exec_ref.svh
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// 32-bit xorshift step
function automatic word_t xorshift(input word_t x);
    word_t s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// register result for ALU ops, LUI, AUIPC and the jumps
function automatic word_t ref_value(input exec_op_e o, input logic use_imm,
                                    input word_t pc, input word_t imm,
                                    input word_t rs1, input word_t rs2);
    word_t b;
    b = use_imm ? imm : rs2;
    case (o)
        ADD:   return rs1 + b;
        SUB:   return rs1 - b;
        SLL:   return rs1 << b[4:0];
        SLT:   return ($signed(rs1) < $signed(b)) ? 32'd1 : 32'd0;
        SLTU:  return (rs1 < b) ? 32'd1 : 32'd0;
        XOR:   return rs1 ^ b;
        SRL:   return rs1 >> b[4:0];
        SRA:   return $signed(rs1) >>> b[4:0];
        OR:    return rs1 | b;
        AND:   return rs1 & b;
        LUI:   return imm;
        AUIPC: return pc + imm;
        default: return pc + 32'd4;
    endcase
endfunction

function automatic logic ref_taken(input exec_op_e o, input word_t rs1, input word_t rs2);
    case (o)
        BEQ:  return rs1 == rs2;
        BNE:  return rs1 != rs2;
        BLT:  return $signed(rs1) < $signed(rs2);
        BGE:  return $signed(rs1) >= $signed(rs2);
        BLTU: return rs1 < rs2;
        BGEU: return rs1 >= rs2;
        default: return 1'b0;
    endcase
endfunction

function automatic word_t ref_next_pc(input exec_op_e o, input word_t pc, input word_t imm,
                                      input word_t rs1, input word_t rs2);
    word_t t;
    if (o == JALR) begin
        t = rs1 + imm;
        return {t[31:1], 1'b0};
    end
    if (o == JAL || ref_taken(o, rs1, rs2)) begin
        return pc + imm;
    end
    return pc + 32'd4;
endfunction

function automatic logic ref_reg_write(input exec_op_e o, input reg_idx_t rd);
    return (o inside {[ADD:JALR], LOAD}) && (rd != 4'd0);
endfunction

`endif

//--- tb/tb_exec_top.sv
`timescale 1ns/1ps

module tb_exec_top;
    import exec_pkg::*;

    `include "exec_ref.svh"

    // limit is three times the rough cycle budget of all tests
    localparam int STIM_CYCLES = 1600;
    localparam int LIMIT       = 3 * STIM_CYCLES;

    typedef struct {
        exec_op_e  op;
        logic      use_imm;
        mem_size_e size;
        logic      uns;
        reg_idx_t  rd;
        reg_idx_t  rs1_idx;
        reg_idx_t  rs2_idx;
        word_t     pc;
        word_t     imm;
        word_t     rs1;
        word_t     rs2;
    } instr_t;

    typedef struct {
        instr_t in;
        word_t  value;
        logic   check_value;
        logic   wr;
        word_t  npc;
        logic   is_mem;
        int     issue_cyc;
        logic   check_lat;
    } expect_t;

    logic clock;
    logic reset;
    logic issue_valid;
    logic issue_ready;
    exec_op_e op;
    logic use_imm;
    mem_size_e issue_size;
    logic issue_unsigned;
    reg_idx_t rd;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t pc;
    word_t imm;
    word_t rs1;
    word_t rs2;
    logic result_valid;
    logic result_ready;
    reg_idx_t result_rd;
    word_t result_value;
    logic reg_write;
    logic mem_enable;
    logic mem_write;
    word_t mem_addr;
    word_t mem_wdata;
    mem_size_e mem_size;
    logic mem_unsigned;
    word_t next_pc;
    logic wb_done;
    reg_idx_t wb_rd;

    word_t    rng_state;
    word_t    ready_rng;
    int       cyc;
    int       errors;
    int       results;
    logic     auto_wb;
    logic     ready_random;
    logic     front_seen;
    expect_t  front;
    expect_t  exp_q[$];
    reg_idx_t wb_req[$];

    exec_top dut (.*);

    always #10 clock = ~clock;

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_size(input string name, input mem_size_e got, input mem_size_e exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %s expected %s", $time, name, got.name(),
                     exp.name());
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic word_t next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic instr_t random_instr(input exec_op_e o);
        instr_t in;
        in.op      = o;
        in.use_imm = 1'(next_rand() % 2);
        in.size    = mem_size_e'(next_rand() % 3);
        in.uns     = 1'(next_rand() % 2);
        in.rd      = reg_idx_t'(next_rand());
        in.rs1_idx = reg_idx_t'(next_rand());
        in.rs2_idx = reg_idx_t'(next_rand());
        in.pc      = (next_rand() % 32'h10000) << 2;
        in.imm     = next_rand();
        // x0 reads zero
        in.rs1     = (in.rs1_idx == 0) ? '0 : next_rand();
        in.rs2     = (in.rs2_idx == 0) ? '0 : next_rand();
        // some equal operands so branch-equal paths get hit
        if (next_rand() % 4 == 0) begin
            in.rs2 = in.rs1;
        end
        return in;
    endfunction

    function automatic expect_t expect_of(input instr_t in, input logic lat);
        expect_t e;
        e.in          = in;
        e.value       = ref_value(in.op, in.use_imm, in.pc, in.imm, in.rs1, in.rs2);
        e.check_value = in.op inside {[ADD:JALR]};
        e.wr          = ref_reg_write(in.op, in.rd);
        e.npc         = ref_next_pc(in.op, in.pc, in.imm, in.rs1, in.rs2);
        e.is_mem      = in.op inside {LOAD, STORE};
        e.check_lat   = lat;
        return e;
    endfunction

    // ------------------------------------------------------------------------
    // stimulus helpers called 2 ns after a rising edge
    // ------------------------------------------------------------------------

    task automatic issue(input instr_t in, input int max_wait, input logic lat,
                         output logic ok);
        int waited;
        expect_t e;
        op = in.op;
        use_imm = in.use_imm;
        issue_size = in.size;
        issue_unsigned = in.uns;
        rd = in.rd;
        rs1_idx = in.rs1_idx;
        rs2_idx = in.rs2_idx;
        pc = in.pc;
        imm = in.imm;
        rs1 = in.rs1;
        rs2 = in.rs2;
        issue_valid = 1'b1;
        ok = 1'b0;
        waited = 0;
        while (!ok && waited < max_wait) begin
            @(posedge clock);
            if (issue_ready) begin
                ok = 1'b1;
                e = expect_of(in, lat);
                e.issue_cyc = cyc;
                exp_q.push_back(e);
            end
            waited++;
        end
        #2;
        issue_valid = 1'b0;
    endtask

    task automatic issue_must(input instr_t in, input logic lat);
        logic ok;
        issue(in, 40, lat, ok);
        if (!ok) begin
            $display("instruction %s was never accepted", in.op.name());
            errors++;
        end
    endtask

    task automatic drain();
        while (exp_q.size() > 0) begin
            @(posedge clock);
        end
        #2;
    endtask

    // ------------------------------------------------------------------------
    // result checker and write-back model
    // ------------------------------------------------------------------------

    always @(posedge clock) begin
        cyc <= cyc + 1;
        if (!reset) begin
            if (result_valid && issue_ready) begin
                $display("issue_ready was high while a result waited at %0t", $time);
                errors++;
            end
            if (result_valid && exp_q.size() == 0) begin
                $display("a result appeared with nothing outstanding at %0t", $time);
                errors++;
            end else if (result_valid) begin
                front = exp_q[0];
                // valid rises at issue edge + 2 and is first sampled one edge later
                if (!front_seen && front.check_lat && cyc - front.issue_cyc != 3) begin
                    $display("result latency was %0d cycles, not 2", cyc - front.issue_cyc - 1);
                    errors++;
                end
                front_seen = 1'b1;
                check_idx("result_rd", result_rd, front.in.rd);
                check_bit("reg_write", reg_write, front.wr);
                check_word("next_pc", next_pc, front.npc);
                check_bit("mem_enable", mem_enable, front.is_mem);
                check_bit("mem_write", mem_write, front.in.op == STORE);
                if (front.check_value) begin
                    check_word("result_value", result_value, front.value);
                end
                if (front.is_mem) begin
                    check_word("mem_addr", mem_addr, front.in.rs1 + front.in.imm);
                    check_word("mem_wdata", mem_wdata, front.in.rs2);
                    check_size("mem_size", mem_size, front.in.size);
                    check_bit("mem_unsigned", mem_unsigned, front.in.uns);
                end
                if (result_ready) begin
                    void'(exp_q.pop_front());
                    front_seen = 1'b0;
                    results++;
                    if (auto_wb && front.in.op == LOAD && front.in.rd != 0) begin
                        wb_req.push_back(front.in.rd);
                    end
                end
            end
        end
    end

    always @(posedge clock) begin
        #2;
        if (wb_req.size() > 0) begin
            wb_done = 1'b1;
            wb_rd = wb_req.pop_front();
        end else begin
            wb_done = 1'b0;
        end
        ready_rng = xorshift(ready_rng);
        result_ready = ready_random ? ready_rng[7] : 1'b1;
    end

    always @(posedge clock) begin
        if (cyc >= LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cyc);
            $display("Errors found");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------

    initial begin
        instr_t in;
        logic ok;
        clock = 0;
        reset = 1;
        issue_valid = 0;
        op = ADD;
        use_imm = 0;
        issue_size = MEM_WORD;
        issue_unsigned = 0;
        rd = 0;
        rs1_idx = 0;
        rs2_idx = 0;
        pc = 0;
        imm = 0;
        rs1 = 0;
        rs2 = 0;
        result_ready = 1;
        wb_done = 0;
        wb_rd = 0;
        rng_state = 32'd23364;
        ready_rng = xorshift(32'd23364 ^ 32'h5a5a5a5a);
        cyc = 0;
        errors = 0;
        results = 0;
        auto_wb = 1;
        ready_random = 0;
        front_seen = 0;
        repeat (3) @(posedge clock);
        #2;
        reset = 0;
        @(posedge clock);
        check_bit("issue_ready", issue_ready, 1'b1);
        check_bit("result_valid", result_valid, 1'b0);
        #2;

        // random ALU, LUI and AUIPC ops
        repeat (200) begin
            issue_must(random_instr(exec_op_e'(next_rand() % 12)), 1'b1);
        end
        drain();
        $display("test 1 alu ops finished, errors so far %0d", errors);

        // branches and jumps
        repeat (4) begin
            for (int k = BEQ; k <= BGEU; k++) begin
                issue_must(random_instr(exec_op_e'(k)), 1'b1);
            end
            issue_must(random_instr(JAL), 1'b1);
            issue_must(random_instr(JALR), 1'b1);
        end
        drain();
        $display("test 2 branches finished, errors so far %0d", errors);

        // loads and stores over every size and signedness, twice each
        for (int s = 0; s < 3; s++) begin
            for (int u = 0; u < 8; u++) begin
                in = random_instr(u[1] ? STORE : LOAD);
                in.size = mem_size_e'(s);
                in.uns = u[0];
                issue_must(in, 1'b1);
            end
        end
        drain();
        $display("test 3 memory ops finished, errors so far %0d", errors);

        // random back-pressure
        ready_random = 1;
        repeat (60) begin
            issue_must(random_instr(exec_op_e'(next_rand() % 22)), 1'b0);
        end
        drain();
        ready_random = 0;
        $display("test 4 back-pressure finished, errors so far %0d", errors);

        // load-use lock on x5 with a reader and then a writer
        auto_wb = 0;
        for (int v = 0; v < 2; v++) begin
            in = random_instr(LOAD);
            in.rd = 5;
            in.rs1_idx = 1;
            in.rs2_idx = 2;
            issue_must(in, 1'b1);
            drain();
            in = random_instr(ADD);
            in.rd = 3;
            in.rs1_idx = 1;
            in.rs2_idx = 2;
            issue(in, 10, 1'b1, ok);
            if (!ok) begin
                $display("independent instruction was held by the lock");
                errors++;
            end
            drain();
            in = random_instr(ADD);
            in.rd = (v == 0) ? 4'd7 : 4'd5;
            in.rs1_idx = (v == 0) ? 4'd5 : 4'd1;
            in.rs2_idx = 2;
            issue(in, 8, 1'b1, ok);
            if (ok) begin
                $display("dependent instruction issued before write-back");
                errors++;
            end
            wb_req.push_back(4'd5);
            issue_must(in, 1'b1);
            drain();
        end
        auto_wb = 1;
        $display("test 5 load-use lock finished, errors so far %0d", errors);

        // load to x0 takes no lock
        in = random_instr(LOAD);
        in.rd = 0;
        issue_must(in, 1'b1);
        in = random_instr(ADD);
        in.rs1_idx = 0;
        in.rs1 = 0;
        issue(in, 10, 1'b1, ok);
        if (!ok) begin
            $display("instruction after a load to x0 was held");
            errors++;
        end
        drain();
        $display("test 6 load to x0 finished, errors so far %0d", errors);

        $display("results checked %0d, errors %0d", results, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
